//--- logic/pd_macros.svh
`ifndef PD_MACROS_SVH
`define PD_MACROS_SVH

// Word and address sizes
`define PD_WORD_W 16
`define PD_ADDR_W 16
`define PD_OP_W 6
`define PD_R0_W 9

// Opcode group bounds, octal as in the instruction list
`define PD_OP_NORM_LO 6'o20
`define PD_OP_NORM_HI 6'o57
`define PD_OP_KA1_LO 6'o60
`define PD_OP_KA1_HI 6'o67
`define PD_OP_JUMP 6'o70
`define PD_OP_SYS 6'o74

`define PD_RESET_ADR 16'h0000

// Bit positions inside upper R0 (Z M V C L E G Y X)
`define PD_R0_Z 0
`define PD_R0_M 1
`define PD_R0_C 3
`define PD_R0_L 4
`define PD_R0_E 5
`define PD_R0_G 6

`endif

//--- logic/pd_pkg.sv
`include "pd_macros.svh"

package pd_pkg;

	// Memory word, bit 0 is the MSB as on the machine
	typedef logic [0:`PD_WORD_W-1] word_t;

	// Word address
	typedef logic [0:`PD_ADDR_W-1] addr_t;

	// Upper R0, bits Z M V C L E G Y X
	typedef logic [0:`PD_R0_W-1] r0_flags_t;

	// Instruction groups seen by the execution side
	typedef enum logic [2:0] {
		CLS_ILLEGAL,	// Opcodes 000..017
		CLS_NORM,		// Normal argument, 020..057
		CLS_KA1,		// Short argument, 060..067
		CLS_JUMP,		// Conditional jumps, 070
		CLS_SYS,		// System group, 074
		CLS_MISC		// Everything else that is legal
	} instr_class_e;

	// Fetch sequencer
	typedef enum logic [1:0] {
		FS_IDLE,		// Out of reset
		FS_INSTR,		// Reading the instruction word
		FS_ARG,			// Gap cycle, then argument read
		FS_HOLD			// Record complete, waiting for take
	} fetch_state_e;

	// Fetch to decode
	typedef struct packed {
		word_t ir;			// Instruction register
		word_t arg;			// Argument word, zero if none
		addr_t pc;			// Address of the instruction word
		logic two_word;		// C field was zero
	} fetch_rec_s;

	// Decode to execution
	typedef struct packed {
		instr_class_e cls;	// Group
		word_t ir;
		word_t arg;
		addr_t pc;
		logic two_word;
		logic xi;			// Illegal instruction
		logic nef;			// Ineffective instruction
	} dec_rec_s;

	// Record widths
	//   fetch_rec_s  16 + 16 + 16 + 1      = 49
	//   dec_rec_s    3 + 16 + 16 + 16 + 3  = 54

endpackage

//--- logic/ir_fetch.sv
`timescale 1ns/1ps
`include "pd_macros.svh"

module ir_fetch import pd_pkg::*; (
	input  logic       strob1,			// Main clock
	input  logic       rst,				// Sync reset
	output logic       wb_cyc,			// Bus cycle
	output logic       wb_stb,			// Strobe, held until ack
	output logic       wb_we,			// Read only master
	output addr_t      wb_adr,			// Word address
	input  word_t      wb_dat_i,		// Read data
	input  logic       wb_ack,			// Read done
	input  logic       take,			// Issue side accepts record
	input  logic       redirect,		// Effective jump with argument
	input  addr_t      redirect_adr,	// Jump target
	output fetch_rec_s fetch_rec,		// Fetched instruction
	output logic       fetch_valid		// Record complete
);

	fetch_state_e state;
	word_t ir;					// Instruction register
	word_t arg;					// Argument register
	addr_t pc;					// Address of current instruction
	logic two_word;				// Argument word follows
	logic c0;					// C field of incoming word is zero
	logic hand_off;				// Record leaves this cycle
	logic instr_done;			// Instruction word arrives
	logic arg_done;				// Argument word arrives
	addr_t seq_adr;				// Next sequential instruction

	assign c0 = (wb_dat_i[13:15] == 3'd0);
	assign hand_off = fetch_valid & take;
	assign instr_done = (state == FS_INSTR) & wb_stb & wb_ack;
	assign arg_done = (state == FS_ARG) & wb_stb & wb_ack;
	assign seq_adr = pc + (two_word ? addr_t'(2) : addr_t'(1));

	assign wb_we = 1'b0;
	assign wb_adr = (state == FS_ARG) ? pc + addr_t'(1) : pc;	// Argument sits after IR word

	always_ff @(posedge strob1) begin
		if (rst) begin
			state <= FS_IDLE;
			pc <= `PD_RESET_ADR;
			wb_cyc <= 1'b0;
			wb_stb <= 1'b0;
			fetch_valid <= 1'b0;
		end else begin
			case (state)
				FS_IDLE: begin
					wb_cyc <= 1'b1;				// First read right after reset
					wb_stb <= 1'b1;
					state <= FS_INSTR;
				end
				FS_INSTR: begin
					if (instr_done) begin
						wb_cyc <= 1'b0;
						wb_stb <= 1'b0;
						if (c0) begin
							state <= FS_ARG;		// Bus idles one cycle first
						end else begin
							state <= FS_HOLD;
							fetch_valid <= 1'b1;
						end
					end
				end
				FS_ARG: begin
					if (!wb_cyc) begin
						wb_cyc <= 1'b1;				// Start argument read
						wb_stb <= 1'b1;
					end else if (arg_done) begin
						wb_cyc <= 1'b0;
						wb_stb <= 1'b0;
						fetch_valid <= 1'b1;
						state <= FS_HOLD;
					end
				end
				FS_HOLD: begin
					if (hand_off) begin
						fetch_valid <= 1'b0;
						pc <= redirect ? redirect_adr : seq_adr;
						wb_cyc <= 1'b1;				// Bus was idle during hold
						wb_stb <= 1'b1;
						state <= FS_INSTR;
					end
				end
				default: state <= FS_IDLE;
			endcase
		end
	end

	always_ff @(posedge strob1) begin
		if (instr_done) begin
			ir <= wb_dat_i;
			arg <= '0;							// Single word leaves it clear
			two_word <= c0;
		end
		if (arg_done)
			arg <= wb_dat_i;
	end

	assign fetch_rec.ir = ir;
	assign fetch_rec.arg = arg;
	assign fetch_rec.pc = pc;
	assign fetch_rec.two_word = two_word;

	// Cycle closes right after ack
	a_cyc_drop: assert property (@(posedge strob1) disable iff (rst)
		wb_stb && wb_ack |=> !wb_cyc && !wb_stb);
	a_adr_hold: assert property (@(posedge strob1) disable iff (rst)
		wb_stb && !wb_ack |=> wb_stb && $stable(wb_adr));

endmodule

//--- logic/pd_decode.sv
`timescale 1ns/1ps
`include "pd_macros.svh"

module pd_decode import pd_pkg::*; (
	input  fetch_rec_s fetch_rec,		// Record from fetch
	input  r0_flags_t  r0,				// Upper R0, CPU flags
	input  logic       q,				// User mode
	input  logic       p,				// Skip flag
	output dec_rec_s   dec_next,		// Decoded record toward issue
	output logic       redirect,		// Load PC from argument
	output addr_t      redirect_adr		// Jump target
);

	logic [0:`PD_OP_W-1] op;	// Opcode field ir[0:5]
	logic [0:2] a_fld;			// Register / condition field ir[7:9]
	instr_class_e cls;
	logic is_jump;
	logic is_sys;
	logic sys_bad_a;			// A of 5, 6 or 7 in system group
	logic cond;					// Jump condition met
	logic xi;
	logic nef;

	assign op = fetch_rec.ir[0:5];
	assign a_fld = fetch_rec.ir[7:9];

	// Opcode groups
	always_comb begin
		if (op < `PD_OP_NORM_LO)
			cls = CLS_ILLEGAL;						// Nothing assigned below 020
		else if (op <= `PD_OP_NORM_HI)
			cls = CLS_NORM;
		else if (op >= `PD_OP_KA1_LO && op <= `PD_OP_KA1_HI)
			cls = CLS_KA1;
		else if (op == `PD_OP_JUMP)
			cls = CLS_JUMP;
		else if (op == `PD_OP_SYS)
			cls = CLS_SYS;
		else
			cls = CLS_MISC;							// ALU, byte, shift, FP subgroups
	end

	assign is_jump = (cls == CLS_JUMP);
	assign is_sys = (cls == CLS_SYS);

	// Jump condition from A field
	always_comb begin
		case (a_fld)
			3'd0: cond = 1'b1;						// UJ
			3'd1: cond = r0[`PD_R0_L];				// JL
			3'd2: cond = r0[`PD_R0_E];				// JE
			3'd3: cond = r0[`PD_R0_G];				// JG
			3'd4: cond = r0[`PD_R0_Z];				// JZ
			3'd5: cond = r0[`PD_R0_M];				// JM
			3'd6: cond = ~r0[`PD_R0_E];			// JN
			default: cond = r0[`PD_R0_C];			// A=7, JCS
		endcase
	end

	// Upper three system opcodes are not implemented
	assign sys_bad_a = a_fld[0] & (a_fld[1] | a_fld[2]);

	// System group is privileged
	assign xi = (cls == CLS_ILLEGAL)
		| (is_sys & q)
		| (is_sys & sys_bad_a);

	// P skips the instruction, failed condition makes a jump a no-op
	assign nef = xi | p | (is_jump & ~cond);

	// Only a taken jump with an argument word moves PC
	assign redirect = is_jump & ~nef & fetch_rec.two_word;
	assign redirect_adr = fetch_rec.arg;

	assign dec_next.cls = cls;
	assign dec_next.ir = fetch_rec.ir;
	assign dec_next.arg = fetch_rec.arg;
	assign dec_next.pc = fetch_rec.pc;
	assign dec_next.two_word = fetch_rec.two_word;
	assign dec_next.xi = xi;
	assign dec_next.nef = nef;

endmodule

//--- logic/pd_issue.sv
`timescale 1ns/1ps

module pd_issue import pd_pkg::*; (
	input  logic     strob1,		// Main clock
	input  logic     rst,			// Sync reset
	input  dec_rec_s dec_next,		// Decoded record from decode
	input  logic     fetch_valid,	// Fetch holds a complete record
	output logic     take,			// Record accepted this cycle
	output dec_rec_s dec_rec,		// Record toward execution
	output logic     dec_valid,		// Output register full
	input  logic     dec_ready		// Execution side accepts
);

	logic load;						// Hand-off from fetch

	// Empty, or emptying at this edge
	assign take = ~dec_valid | dec_ready;
	assign load = fetch_valid & take;

	always_ff @(posedge strob1) begin
		if (rst)
			dec_valid <= 1'b0;
		else if (load)
			dec_valid <= 1'b1;			// New record replaces the leaving one
		else if (dec_ready)
			dec_valid <= 1'b0;
	end

	always_ff @(posedge strob1) begin
		if (load)
			dec_rec <= dec_next;
	end

	// Record frozen while execution stalls
	a_rec_hold: assert property (@(posedge strob1) disable iff (rst)
		dec_valid && !dec_ready |=> dec_valid && $stable(dec_rec));

	// Fetch keeps offering until the record is taken
	a_fetch_hold: assert property (@(posedge strob1) disable iff (rst)
		fetch_valid && !take |=> fetch_valid);

endmodule

//--- logic/pd_top.sv
`timescale 1ns/1ps

module pd_top import pd_pkg::*; (
	input  logic      strob1,		// Main clock
	input  logic      rst,			// Sync reset
	output logic      wb_cyc,		// Wishbone master, reads only
	output logic      wb_stb,
	output logic      wb_we,
	output addr_t     wb_adr,
	input  word_t     wb_dat_i,
	input  logic      wb_ack,
	input  r0_flags_t r0,			// CPU flags, stable during decode
	input  logic      q,			// User mode
	input  logic      p,			// Skip flag
	output dec_rec_s  dec_rec,		// Decoded record
	output logic      dec_valid,
	input  logic      dec_ready
);

	fetch_rec_s fetch_rec;
	logic fetch_valid;
	dec_rec_s dec_next;
	logic redirect;
	addr_t redirect_adr;
	logic take;

	ir_fetch fetch (
		.strob1(strob1), .rst(rst),
		.wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
		.wb_dat_i(wb_dat_i), .wb_ack(wb_ack),
		.take(take), .redirect(redirect), .redirect_adr(redirect_adr),
		.fetch_rec(fetch_rec), .fetch_valid(fetch_valid)
	);

	pd_decode decode (
		.fetch_rec(fetch_rec), .r0(r0), .q(q), .p(p),
		.dec_next(dec_next), .redirect(redirect), .redirect_adr(redirect_adr)
	);

	pd_issue issue (
		.strob1(strob1), .rst(rst),
		.dec_next(dec_next), .fetch_valid(fetch_valid), .take(take),
		.dec_rec(dec_rec), .dec_valid(dec_valid), .dec_ready(dec_ready)
	);

endmodule

//--- verification/pd_vectors.svh
`ifndef PD_VECTORS_SVH
`define PD_VECTORS_SVH

// Columns: pc, ir, arg, two_word, cls, xi, nef, r0 (Z M V C L E G Y X), q, p
// Each row is also the program: ir at pc, arg at pc+1 when two_word

typedef struct packed {
	addr_t pc;				// Address of the instruction word
	word_t ir;
	word_t arg;				// Zero for single-word instructions
	logic two_word;
	instr_class_e cls;
	logic xi;
	logic nef;
	r0_flags_t r0;			// Flags in force while decoded
	logic q;
	logic p;
} row_s;

localparam int N_ROWS = 34;

row_s rows [N_ROWS];

task automatic load_rows();
	rows[0] = '{16'd0, 16'h4053, '0, '0, CLS_NORM, '0, '0, 9'h000, '0, '0};		// 020
	rows[1] = '{16'd1, 16'hBC80, 16'h1234, '1, CLS_NORM, '0, '0, 9'h000, '0, '0};	// 057, C=0
	rows[2] = '{16'd3, 16'hC0C5, '0, '0, CLS_KA1, '0, '0, 9'h000, '0, '0};
	rows[3] = '{16'd4, 16'hDC40, 16'h00FF, '1, CLS_KA1, '0, '0, 9'h000, '0, '0};
	rows[4] = '{16'd6, 16'h2001, '0, '0, CLS_ILLEGAL, '1, '1, 9'h000, '0, '0};		// 010
	rows[5] = '{16'd7, 16'h0000, 16'h5555, '1, CLS_ILLEGAL, '1, '1, 9'h000, '0, '0};
	rows[6] = '{16'd9, 16'hF001, '0, '0, CLS_SYS, '0, '0, 9'h000, '0, '0};
	rows[7] = '{16'd10, 16'hF081, '0, '0, CLS_SYS, '1, '1, 9'h000, '1, '0};		// User mode
	rows[8] = '{16'd11, 16'hF141, '0, '0, CLS_SYS, '1, '1, 9'h000, '0, '0};		// A=5
	rows[9] = '{16'd12, 16'hF1C1, '0, '0, CLS_SYS, '1, '1, 9'h000, '0, '0};		// A=7
	rows[10] = '{16'd13, 16'hE402, '0, '0, CLS_MISC, '0, '0, 9'h000, '0, '0};		// 071
	rows[11] = '{16'd14, 16'hFC04, '0, '0, CLS_MISC, '0, '0, 9'h000, '0, '0};		// 077
	rows[12] = '{16'd15, 16'hE000, 16'd18, '1, CLS_JUMP, '0, '0, 9'h000, '0, '0};	// UJ
	rows[13] = '{16'd18, 16'hE040, 16'd21, '1, CLS_JUMP, '0, '0, 9'h010, '0, '0};	// JL
	rows[14] = '{16'd21, 16'hE040, 16'd64, '1, CLS_JUMP, '0, '1, 9'h000, '0, '0};
	rows[15] = '{16'd23, 16'hE080, 16'd26, '1, CLS_JUMP, '0, '0, 9'h008, '0, '0};	// JE
	rows[16] = '{16'd26, 16'hE080, 16'd64, '1, CLS_JUMP, '0, '1, 9'h000, '0, '0};
	rows[17] = '{16'd28, 16'hE0C0, 16'd31, '1, CLS_JUMP, '0, '0, 9'h004, '0, '0};	// JG
	rows[18] = '{16'd31, 16'hE0C0, 16'd64, '1, CLS_JUMP, '0, '1, 9'h000, '0, '0};
	rows[19] = '{16'd33, 16'hE100, 16'd36, '1, CLS_JUMP, '0, '0, 9'h100, '0, '0};	// JZ
	rows[20] = '{16'd36, 16'hE100, 16'd64, '1, CLS_JUMP, '0, '1, 9'h0FF, '0, '0};
	rows[21] = '{16'd38, 16'hE140, 16'd41, '1, CLS_JUMP, '0, '0, 9'h080, '0, '0};	// JM
	rows[22] = '{16'd41, 16'hE140, 16'd64, '1, CLS_JUMP, '0, '1, 9'h000, '0, '0};
	rows[23] = '{16'd43, 16'hE180, 16'd46, '1, CLS_JUMP, '0, '0, 9'h000, '0, '0};	// JN
	rows[24] = '{16'd46, 16'hE180, 16'd64, '1, CLS_JUMP, '0, '1, 9'h008, '0, '0};
	rows[25] = '{16'd48, 16'hE1C0, 16'd51, '1, CLS_JUMP, '0, '0, 9'h020, '0, '0};	// JCS
	rows[26] = '{16'd51, 16'hE1C0, 16'd64, '1, CLS_JUMP, '0, '1, 9'h1DF, '0, '0};
	rows[27] = '{16'd53, 16'hE001, '0, '0, CLS_JUMP, '0, '0, 9'h000, '0, '0};		// No arg
	rows[28] = '{16'd54, 16'hE000, 16'd64, '1, CLS_JUMP, '0, '1, 9'h000, '0, '1};	// Skipped
	rows[29] = '{16'd56, 16'h4053, '0, '0, CLS_NORM, '0, '1, 9'h000, '0, '1};
	rows[30] = '{16'd57, 16'hF001, '0, '0, CLS_SYS, '0, '1, 9'h000, '0, '1};
	rows[31] = '{16'd58, 16'h4400, 16'hBEEF, '1, CLS_NORM, '0, '0, 9'h000, '0, '0};
	rows[32] = '{16'd60, 16'hC401, '0, '0, CLS_KA1, '0, '0, 9'h000, '0, '0};
	rows[33] = '{16'd61, 16'h5A5B, '0, '0, CLS_NORM, '0, '0, 9'h000, '0, '0};
endtask

`endif

//--- verification/pd_tb.sv
`timescale 1ns/1ps

module pd_tb import pd_pkg::*; ();

	localparam addr_t RESET_ADR = 16'h0000;	// First fetch address

	logic strob1;
	logic rst;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	addr_t wb_adr;
	word_t wb_dat_i;
	logic wb_ack;
	r0_flags_t r0;
	logic q;
	logic p;
	dec_rec_s dec_rec;
	logic dec_valid;
	logic dec_ready;

	`include "pd_vectors.svh"

	word_t mem [0:1023];		// Program memory
	int n_checks;
	int n_fail;
	int n_loaded;				// Records taken into the issue register
	logic dv_q;					// dec_valid before the last edge
	logic rdy_q;				// dec_ready in force at the last edge
	dec_rec_s rec_q;
	int ack_wait;				// Cycles left before wb_ack
	logic ack_busy;				// Read seen, delay chosen

	pd_top uut (
		.strob1(strob1), .rst(rst),
		.wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
		.wb_dat_i(wb_dat_i), .wb_ack(wb_ack),
		.r0(r0), .q(q), .p(p),
		.dec_rec(dec_rec), .dec_valid(dec_valid), .dec_ready(dec_ready)
	);

	initial begin
		strob1 = 1'b0;
		forever #4 strob1 = ~strob1;	// 8 ns period
	end

	task automatic check_val(input string name, input logic [63:0] exp_v,
			input logic [63:0] got_v);
		n_checks++;
		assert (got_v === exp_v) else begin
			$display("ERR %0t %s expected %h got %h", $time, name, exp_v, got_v);
			n_fail++;
		end
	endtask

	task automatic apply_flags(input int idx);
		r0 = rows[idx].r0;
		q = rows[idx].q;
		p = rows[idx].p;
	endtask

	task automatic fill_memory();
		int a;
		int k;
		logic [9:0] a10;
		for (a = 0; a < 1024; a++)
			mem[a] = {6'o01, 10'(a)};			// Illegal filler, tagged with address
		for (k = 0; k < N_ROWS; k++) begin
			a10 = rows[k].pc[6:15];
			mem[a10] = rows[k].ir;
			if (rows[k].two_word)
				mem[a10 + 10'd1] = rows[k].arg;		// Argument follows instruction
		end
	endtask

	task automatic service_cycle(output logic accepted);
		@(negedge strob1);
		if (dv_q && !rdy_q) begin					// Stalled at the last edge
			check_val("dec_valid", 64'(1'b1), 64'(dec_valid));
			check_val("dec_rec", 64'(rec_q), 64'(dec_rec));
		end
		if (dec_valid && (!dv_q || rdy_q)) begin	// Issue register loaded at the last edge
			n_loaded++;
			if (n_loaded < N_ROWS)
				apply_flags(n_loaded);				// Fetch now works on the next row
		end
		dec_ready = ($urandom % 3) != 0;			// Stall about one cycle in three
		accepted = dec_valid && dec_ready;
		dv_q = dec_valid;
		rdy_q = dec_ready;
		rec_q = dec_rec;
	endtask

	task automatic check_record(input int idx);
		check_val("dec_rec.pc", 64'(rows[idx].pc), 64'(dec_rec.pc));
		check_val("dec_rec.ir", 64'(rows[idx].ir), 64'(dec_rec.ir));
		check_val("dec_rec.arg", 64'(rows[idx].arg), 64'(dec_rec.arg));
		check_val("dec_rec.two_word", 64'(rows[idx].two_word), 64'(dec_rec.two_word));
		check_val("dec_rec.cls", 64'(rows[idx].cls), 64'(dec_rec.cls));
		check_val("dec_rec.xi", 64'(rows[idx].xi), 64'(dec_rec.xi));
		check_val("dec_rec.nef", 64'(rows[idx].nef), 64'(dec_rec.nef));
	endtask

	// Wishbone slave, random wait states
	initial begin
		ack_busy = 1'b0;
		ack_wait = 0;
		forever begin
			@(negedge strob1);
			if (wb_ack) begin						// Ack seen at the last edge
				check_val("wb_cyc", 64'(1'b0), 64'(wb_cyc));
				check_val("wb_stb", 64'(1'b0), 64'(wb_stb));
			end
			if (wb_cyc && wb_stb && !wb_ack) begin
				if (!ack_busy) begin
					ack_busy = 1'b1;
					ack_wait = $urandom % 4;		// 0 to 3 wait cycles
				end
				if (ack_wait == 0) begin
					check_val("wb_we", 64'(1'b0), 64'(wb_we));
					wb_dat_i = mem[wb_adr[6:15]];
					wb_ack = 1'b1;
					ack_busy = 1'b0;
				end else begin
					ack_wait--;
				end
			end else begin
				wb_ack = 1'b0;
			end
		end
	end

	initial begin
		repeat (N_ROWS * 40 + 10) @(posedge strob1);
		$display("Watchdog: run did not finish within %0d cycles", N_ROWS * 40 + 10);
		$display("*** TEST FAILED ***");
		$finish;
	end

	initial begin
		logic accepted;
		int fail_before;
		int i;
		void'($urandom(69));
		rst = 1'b1;
		wb_ack = 1'b0;
		wb_dat_i = '0;
		dec_ready = 1'b0;
		n_checks = 0;
		n_fail = 0;
		n_loaded = 0;
		dv_q = 1'b0;
		rdy_q = 1'b0;
		rec_q = '0;
		load_rows();
		fill_memory();
		apply_flags(0);
		repeat (2) @(posedge strob1);
		@(negedge strob1);
		fail_before = n_fail;
		check_val("wb_cyc", 64'(1'b0), 64'(wb_cyc));		// Bus idle in reset
		check_val("wb_stb", 64'(1'b0), 64'(wb_stb));
		check_val("dec_valid", 64'(1'b0), 64'(dec_valid));
		rst = 1'b0;
		@(negedge strob1);
		check_val("wb_cyc", 64'(1'b1), 64'(wb_cyc));		// Read starts after release
		check_val("wb_stb", 64'(1'b1), 64'(wb_stb));
		check_val("wb_adr", 64'(RESET_ADR), 64'(wb_adr));
		$display("reset: %s", (n_fail == fail_before) ? "ok" : "mismatch");
		for (i = 0; i < N_ROWS; i++) begin
			fail_before = n_fail;
			accepted = 1'b0;
			while (!accepted)
				service_cycle(accepted);
			check_record(i);
			$display("row %0d pc %h ir %h: %s", i, rows[i].pc, rows[i].ir,
				(n_fail == fail_before) ? "ok" : "mismatch");
		end
		$display("checks %0d, passed %0d, failed %0d", n_checks, n_checks - n_fail, n_fail);
		if (n_fail == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

//--- filelist.f
+incdir+logic
+incdir+verification
logic/pd_pkg.sv
logic/ir_fetch.sv
logic/pd_decode.sv
logic/pd_issue.sv
logic/pd_top.sv
verification/pd_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the fetch/decode testbench with Verilator, runs it and checks the log

set -u
cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_EXE=pd_tb_sim
LOG_FILE=sim.log

verilator --binary --timing --assert \
	-f filelist.f \
	--top-module pd_tb \
	--Mdir "$BUILD_DIR" \
	-o "$SIM_EXE"
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$BUILD_DIR/$SIM_EXE" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

grep -qF "*** TEST PASSED ***" "$LOG_FILE"
if [ $? -ne 0 ]; then
	echo "Pass line not found in $LOG_FILE"
	exit 1
fi

echo "Simulation passed"
exit 0
